/* Makefile */
# Verilator build and run for the mouse cursor testbench

VERILATOR ?= verilator
TOP       ?= tb_mouse_cursor
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/mouse_cursor_properties.sv */
`timescale 1ns/1ps

module mouse_cursor_properties (
    input logic                      clk,
    input logic                      rst_n,
    input mouse_pkg::packet_state_t  state,
    input logic                      rx_strobe,
    input logic                      rx_error,
    input logic                      pixel,
    input logic                      blank_out
);
    import mouse_pkg::*;

    logic valid;

    // valid is high exactly while the fsm sits in emit
    assign valid = (state == emit);

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
        else $error("packet valid lasted more than one cycle");

    no_pixel_in_blank: assert property (@(posedge clk) disable iff (!rst_n) !(pixel && blank_out))
        else $error("pixel lit while blank_out is high");

    strobe_error_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_strobe && rx_error))
        else $error("rx_strobe and rx_error high in the same cycle");

endmodule

// the fsm instance carries no video, the overlay instance carries no ps2 traffic
bind ps2_packet_fsm mouse_cursor_properties u_fsm_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .rx_strobe(rx_strobe),
    .rx_error (rx_error),
    .pixel    (1'b0),
    .blank_out(1'b1)
);

bind crosshair_overlay mouse_cursor_properties u_overlay_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (mouse_pkg::wait_b1),
    .rx_strobe(1'b0),
    .rx_error (1'b0),
    .pixel    (pixel),
    .blank_out(blank_out)
);

/* dv/tb_input.txt */
# byte1 byte2 byte3 (hex), parity-corrupt flag for byte1, expected x, y, buttons (decimal)
# cursor starts at 32 24 on a 64 by 48 screen, y moves opposite to ps2 dy
08 05 03 0 37 21 0
09 0a 00 0 47 21 1
38 fb fe 0 42 23 0
4a 7f 02 0 42 21 2
08 7f 00 0 63 21 0
18 80 00 0 0 21 0
08 00 7f 0 0 0 0
28 00 81 0 0 47 0
0c 10 20 1 0 47 0
0c 14 06 0 20 41 4
19 f6 00 0 10 41 1
08 03 04 1 10 41 1
08 01 01 0 11 40 0
3b ff ff 0 10 41 3
5c 64 0a 0 10 31 4
98 10 7f 0 0 31 0
08 20 00 0 32 31 0

/* dv/tb_mouse_cursor.sv */
`timescale 1ns/1ps

module tb_mouse_cursor;
    import mouse_pkg::*;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // ps2 half period long enough for the filter to settle
    localparam int HALF_PERIOD    = 3 * PS2_FILTER_LEN;
    localparam int MAX_GAP        = 40;
    localparam int UPDATE_TIMEOUT = 100;
    localparam int QUIET_WINDOW   = 300;
    localparam int FRAME_TIMEOUT  = 2 * H_TOTAL * V_TOTAL;

    logic     clk;
    logic     rst_n;
    logic     ps2_clk;
    logic     ps2_data;
    coord_t   cursor_x;
    coord_t   cursor_y;
    buttons_t buttons;
    logic     cursor_update;
    logic     pixel;
    logic     hsync;
    logic     vsync;
    logic     blank;

    integer   seed;
    int       update_count;
    coord_t   seen_x;
    coord_t   seen_y;
    buttons_t seen_buttons;

    mouse_cursor_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .buttons      (buttons),
        .cursor_update(cursor_update),
        .pixel        (pixel),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank        (blank)
    );

    always #10 clk = ~clk;

    // the cursor outputs are already valid in the cycle of the update pulse
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            update_count <= 0;
        end
        else if (cursor_update)
        begin
            update_count <= update_count + 1;
            seen_x       <= cursor_x;
            seen_y       <= cursor_y;
            seen_buttons <= buttons;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
            fail_run("stopping at the first mismatch");
        end
    endtask

    // start bit, eight data bits lsb first, odd parity, stop bit
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            @(posedge clk);
            ps2_data <= bits[i];
            repeat (HALF_PERIOD) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_PERIOD) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (2 * HALF_PERIOD) @(posedge clk);
    endtask

    task automatic wait_for_update(input int start_count, input int line_no);
        int waited;
        waited = 0;
        while (update_count == start_count)
        begin
            if (waited >= UPDATE_TIMEOUT)
                fail_run($sformatf("no cursor_update after packet on line %0d", line_no));
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic expect_no_update(input int start_count, input int cycles, input string what);
        int waited;
        waited = 0;
        while (waited < cycles)
        begin
            if (update_count != start_count)
                fail_run($sformatf("unexpected cursor_update during %s", what));
            @(posedge clk);
            waited++;
        end
    endtask

    // one frame from a vsync rising edge to the next
    task automatic check_frame(input string name);
        int   waited;
        int   hs_pulses;
        int   active;
        int   lit;
        logic prev_vs;
        logic prev_hs;
        logic done;
        waited = 0;
        prev_vs = vsync;
        @(posedge clk);
        while (!(vsync && !prev_vs))
        begin
            if (waited >= FRAME_TIMEOUT)
                fail_run($sformatf("no vsync rising edge found in %s", name));
            prev_vs = vsync;
            @(posedge clk);
            waited++;
        end
        hs_pulses = 0;
        active = 0;
        lit = 0;
        waited = 0;
        prev_hs = hsync;
        done = 1'b0;
        while (!done)
        begin
            if (hsync && !prev_hs)
                hs_pulses++;
            if (!blank)
                active++;
            if (pixel)
                lit++;
            prev_hs = hsync;
            prev_vs = vsync;
            @(posedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT)
                fail_run($sformatf("frame in %s never ended", name));
            done = vsync && !prev_vs;
        end
        check_value({name, " hsync pulses"}, V_TOTAL, hs_pulses);
        check_value({name, " active cycles"}, H_ACTIVE * V_ACTIVE, active);
        check_value({name, " lit pixels"}, H_ACTIVE + V_ACTIVE - 1, lit);
    endtask

    initial
    begin
        int    fd;
        int    code;
        int    line_no;
        int    start;
        int    gap;
        int    b1;
        int    b2;
        int    b3;
        int    flag;
        int    exp_x;
        int    exp_y;
        int    exp_buttons;
        string line;

        clk = 1'b0;
        rst_n <= 1'b0;
        ps2_clk <= 1'b1;
        ps2_data <= 1'b1;
        seed = 32'h4dcb4fae;
        line_no = 0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        check_value("reset cursor_x", H_ACTIVE / 2, cursor_x);
        check_value("reset cursor_y", V_ACTIVE / 2, cursor_y);
        check_value("reset buttons", 0, buttons);
        expect_no_update(0, QUIET_WINDOW, "idle after reset");
        check_frame("frame after reset");

        fd = $fopen("dv/tb_input.txt", "r");
        if (fd == 0)
            fail_run("cannot open dv/tb_input.txt");
        code = $fgets(line, fd);
        while (code != 0)
        begin
            line_no++;
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                code = $sscanf(line, "%h %h %h %d %d %d %d",
                               b1, b2, b3, flag, exp_x, exp_y, exp_buttons);
                if (code != 7)
                    fail_run($sformatf("bad format on line %0d of the data file", line_no));
                start = update_count;
                send_frame(8'(b1), flag != 0);
                send_frame(8'(b2), 1'b0);
                send_frame(8'(b3), 1'b0);
                if (flag != 0)
                begin
                    // corrupt first byte so the fsm drops the rest of the packet
                    expect_no_update(start, UPDATE_TIMEOUT, "a packet with a parity error");
                    check_value($sformatf("line %0d cursor_x", line_no), exp_x, cursor_x);
                    check_value($sformatf("line %0d cursor_y", line_no), exp_y, cursor_y);
                    check_value($sformatf("line %0d buttons", line_no), exp_buttons, buttons);
                end
                else
                begin
                    wait_for_update(start, line_no);
                    check_value($sformatf("line %0d update count", line_no), start + 1,
                                update_count);
                    check_value($sformatf("line %0d cursor_x", line_no), exp_x, seen_x);
                    check_value($sformatf("line %0d cursor_y", line_no), exp_y, seen_y);
                    check_value($sformatf("line %0d buttons", line_no), exp_buttons,
                                seen_buttons);
                end
                gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                repeat (gap) @(posedge clk);
            end
            code = $fgets(line, fd);
        end
        $fclose(fd);

        check_frame("frame after packets");

        $display("TEST PASS");
        $finish;
    end

endmodule

/* list.f */
rtl/mouse_pkg.sv
rtl/mouse_packet_if.sv
rtl/beam_if.sv
rtl/ps2_frame_rx.sv
rtl/ps2_packet_fsm.sv
rtl/cursor_accumulator.sv
rtl/video_timing.sv
rtl/crosshair_overlay.sv
rtl/mouse_cursor_top.sv
dv/mouse_cursor_properties.sv
dv/tb_mouse_cursor.sv

/* rtl/beam_if.sv */
`timescale 1ns/1ps

interface beam_if;
    import mouse_pkg::*;

    coord_t x;
    coord_t y;
    logic   hsync;
    logic   vsync;
    logic   blank;

    modport source (output x, output y, output hsync, output vsync, output blank);
    modport sink (input x, input y, input hsync, input vsync, input blank);

endinterface

/* rtl/crosshair_overlay.sv */
`timescale 1ns/1ps

module crosshair_overlay (
    input  logic              clk,
    input  logic              rst_n,
    input  mouse_pkg::coord_t cursor_x,
    input  mouse_pkg::coord_t cursor_y,
    beam_if.sink              beam,
    output logic              pixel,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              blank_out
);

    // one stage for the pixel, the same stage for sync and blank
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pixel     <= 1'b0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            blank_out <= 1'b1;
        end
        else
        begin
            // light the cursor row and column inside the active area
            pixel     <= !beam.blank && ((beam.x == cursor_x) || (beam.y == cursor_y));
            hsync_out <= beam.hsync;
            vsync_out <= beam.vsync;
            blank_out <= beam.blank;
        end
    end

endmodule

/* rtl/cursor_accumulator.sv */
`timescale 1ns/1ps

module cursor_accumulator #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 48
) (
    input  logic                clk,
    input  logic                rst_n,
    mouse_packet_if.sink        pkt,
    output mouse_pkg::coord_t   cursor_x,
    output mouse_pkg::coord_t   cursor_y,
    output mouse_pkg::buttons_t buttons,
    output logic                cursor_update
);
    import mouse_pkg::*;

    localparam coord_t X_LIMIT = coord_t'(H_ACTIVE - 1);
    localparam coord_t Y_LIMIT = coord_t'(V_ACTIVE - 1);

    logic signed [11:0] sum_x;
    logic signed [11:0] sum_y;
    coord_t             next_x;
    coord_t             next_y;

    // ps2 up is positive, screen y grows downwards
    assign sum_x = $signed({2'b00, cursor_x}) + $signed({{3{pkt.dx[8]}}, pkt.dx});
    assign sum_y = $signed({2'b00, cursor_y}) - $signed({{3{pkt.dy[8]}}, pkt.dy});

    always_comb
    begin
        if (sum_x < 0)
            next_x = '0;
        else if (sum_x > $signed({2'b00, X_LIMIT}))
            next_x = X_LIMIT;
        else
            next_x = sum_x[9:0];

        if (sum_y < 0)
            next_y = '0;
        else if (sum_y > $signed({2'b00, Y_LIMIT}))
            next_y = Y_LIMIT;
        else
            next_y = sum_y[9:0];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cursor_x      <= coord_t'(H_ACTIVE / 2);
            cursor_y      <= coord_t'(V_ACTIVE / 2);
            buttons       <= '0;
            cursor_update <= 1'b0;
        end
        else
        begin
            cursor_update <= pkt.valid;
            if (pkt.valid)
            begin
                cursor_x <= next_x;
                cursor_y <= next_y;
                buttons  <= pkt.buttons;
            end
        end
    end

endmodule

/* rtl/mouse_cursor_top.sv */
`timescale 1ns/1ps

module mouse_cursor_top #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output mouse_pkg::coord_t   cursor_x,
    output mouse_pkg::coord_t   cursor_y,
    output mouse_pkg::buttons_t buttons,
    output logic                cursor_update,
    output logic                pixel,
    output logic                hsync,
    output logic                vsync,
    output logic                blank
);
    import mouse_pkg::*;

    ps2_byte_t rx_byte;
    logic      rx_strobe;
    logic      rx_error;

    mouse_packet_if pkt_bus ();
    beam_if         beam_bus ();

    // receive path, mouse is assumed to be streaming already
    ps2_frame_rx u_frame_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_strobe(rx_strobe),
        .rx_error (rx_error)
    );

    ps2_packet_fsm u_packet_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .rx_strobe(rx_strobe),
        .rx_error (rx_error),
        .pkt      (pkt_bus.source)
    );

    cursor_accumulator #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt          (pkt_bus.sink),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .buttons      (buttons),
        .cursor_update(cursor_update)
    );

    // video path
    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) u_timing (
        .clk  (clk),
        .rst_n(rst_n),
        .beam (beam_bus.source)
    );

    crosshair_overlay u_overlay (
        .clk      (clk),
        .rst_n    (rst_n),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .beam     (beam_bus.sink),
        .pixel    (pixel),
        .hsync_out(hsync),
        .vsync_out(vsync),
        .blank_out(blank)
    );

endmodule

/* rtl/mouse_packet_if.sv */
`timescale 1ns/1ps

interface mouse_packet_if;
    import mouse_pkg::*;

    logic     valid;
    delta_t   dx;
    delta_t   dy;
    buttons_t buttons;

    modport source (output valid, output dx, output dy, output buttons);
    modport sink (input valid, input dx, input dy, input buttons);

endinterface

/* rtl/mouse_pkg.sv */
package mouse_pkg;

    // screen coordinate for beam and cursor
    typedef logic [9:0] coord_t;

    // signed movement, sign bit from byte 1 plus the movement byte
    typedef logic [8:0] delta_t;

    typedef logic [7:0] ps2_byte_t;

    // left, right, middle
    typedef logic [2:0] buttons_t;

    typedef enum logic [1:0] {
        wait_b1,
        wait_b2,
        wait_b3,
        emit
    } packet_state_t;

    // equal samples needed before a filtered line changes
    localparam int PS2_FILTER_LEN = 4;
    // start, 8 data, parity, stop
    localparam int PS2_FRAME_BITS = 11;
    // cycles without a clock edge before a partial frame is dropped
    localparam int PS2_TIMEOUT_CYCLES = 1024;

endpackage

/* rtl/ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    output mouse_pkg::ps2_byte_t rx_byte,
    output logic                 rx_strobe,
    output logic                 rx_error
);
    import mouse_pkg::*;

    localparam int IDLE_W = $clog2(PS2_TIMEOUT_CYCLES);

    logic [1:0]                clk_sync;
    logic [1:0]                data_sync;
    logic [PS2_FILTER_LEN-1:0] clk_hist;
    logic [PS2_FILTER_LEN-1:0] data_hist;
    logic                      clk_filt;
    logic                      data_filt;
    logic                      fall;
    logic                      last_bit;
    logic                      frame_ok;
    logic [9:0]                shift;
    logic [3:0]                bit_cnt;
    logic [IDLE_W-1:0]         idle_cnt;

    // two flop synchronizer feeding a sample history per line
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_hist  <= '1;
            data_hist <= '1;
        end
        else
        begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_hist  <= {clk_hist[PS2_FILTER_LEN-2:0], clk_sync[1]};
            data_hist <= {data_hist[PS2_FILTER_LEN-2:0], data_sync[1]};
        end
    end

    // filtered level only moves once every sample agrees
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clk_filt  <= 1'b1;
            data_filt <= 1'b1;
        end
        else
        begin
            if (&clk_hist)
                clk_filt <= 1'b1;
            else if (~|clk_hist)
                clk_filt <= 1'b0;
            if (&data_hist)
                data_filt <= 1'b1;
            else if (~|data_hist)
                data_filt <= 1'b0;
        end
    end

    assign fall     = clk_filt && (clk_hist == '0);
    assign last_bit = (bit_cnt == 4'(PS2_FRAME_BITS - 1));

    // shift holds start at bit 0, data in 8:1, parity at 9; stop is the current sample
    assign frame_ok = !shift[0] && data_filt && (^shift[9:1]);

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            shift <= {data_filt, shift[9:1]};
            if (last_bit)
                rx_byte <= shift[8:1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bit_cnt   <= '0;
            idle_cnt  <= '0;
            rx_strobe <= 1'b0;
            rx_error  <= 1'b0;
        end
        else
        begin
            rx_strobe <= 1'b0;
            rx_error  <= 1'b0;
            if (fall)
            begin
                idle_cnt <= '0;
                if (last_bit)
                begin
                    bit_cnt   <= '0;
                    rx_strobe <= frame_ok;
                    rx_error  <= !frame_ok;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (bit_cnt != '0)
            begin
                // stalled frame, drop it so the next start bit lines up
                if (idle_cnt == '1)
                begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end
                else
                begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/ps2_packet_fsm.sv */
`timescale 1ns/1ps

module ps2_packet_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mouse_pkg::ps2_byte_t rx_byte,
    input  logic                 rx_strobe,
    input  logic                 rx_error,
    mouse_packet_if.source       pkt
);
    import mouse_pkg::*;

    packet_state_t state;
    ps2_byte_t     byte1;
    ps2_byte_t     byte2;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= wait_b1;
        end
        else if (rx_error)
        begin
            // bad frame, throw away the partial packet
            state <= wait_b1;
        end
        else
        begin
            case (state)
                wait_b1:
                begin
                    // bit 3 is always set in a first byte
                    if (rx_strobe && rx_byte[3])
                        state <= wait_b2;
                end
                wait_b2:
                begin
                    if (rx_strobe)
                        state <= wait_b3;
                end
                wait_b3:
                begin
                    if (rx_strobe)
                        state <= emit;
                end
                default:
                begin
                    state <= wait_b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_strobe && state == wait_b1)
            byte1 <= rx_byte;
        if (rx_strobe && state == wait_b2)
            byte2 <= rx_byte;
    end

    // third byte is still held in rx_byte during emit
    assign pkt.valid   = (state == emit);
    assign pkt.dx      = byte1[6] ? delta_t'(0) : {byte1[4], byte2};
    assign pkt.dy      = byte1[7] ? delta_t'(0) : {byte1[5], rx_byte};
    assign pkt.buttons = byte1[2:0];

endmodule

/* rtl/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 48,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    beam_if.source beam
);
    import mouse_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    coord_t h_cnt;
    coord_t v_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == coord_t'(H_TOTAL - 1))
        begin
            h_cnt <= '0;
            if (v_cnt == coord_t'(V_TOTAL - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign beam.x     = h_cnt;
    assign beam.y     = v_cnt;
    assign beam.blank = (h_cnt >= coord_t'(H_ACTIVE)) || (v_cnt >= coord_t'(V_ACTIVE));

    // both syncs are active high
    assign beam.hsync = (h_cnt >= coord_t'(H_SYNC_START)) &&
                        (h_cnt < coord_t'(H_SYNC_START + H_SYNC));
    assign beam.vsync = (v_cnt >= coord_t'(V_SYNC_START)) &&
                        (v_cnt < coord_t'(V_SYNC_START + V_SYNC));

endmodule
